// ==== rtl/scu_dsp_config.svh ====
`ifndef SCU_DSP_CONFIG_SVH
`define SCU_DSP_CONFIG_SVH

// Bus, RAM word and instruction width
`define SCU_DSP_DATA_W 32

// A and P registers, ACH:ACL and PH:PL
`define SCU_DSP_ACC_W 48

`define SCU_DSP_RAM_AW 6      // 64 words per data RAM

`define SCU_DSP_NUM_BANKS 4   // MD0 to MD3

`define SCU_DSP_PROG_AW 8     // Program RAM address

`define SCU_DSP_IMM_W 8       // Short immediate of MOV SImm

`endif

// ==== rtl/scu_dsp_pkg.sv ====
`include "scu_dsp_config.svh"

package scu_dsp_pkg;

	typedef logic [`SCU_DSP_DATA_W-1:0] data_word_t;
	typedef logic [`SCU_DSP_ACC_W-1:0] acc_word_t;
	typedef logic [`SCU_DSP_RAM_AW-1:0] ram_addr_t;
	typedef logic [$clog2(`SCU_DSP_NUM_BANKS)-1:0] bank_sel_t;
	typedef logic [`SCU_DSP_NUM_BANKS-1:0] bank_mask_t;
	typedef logic [$bits(bank_sel_t)+`SCU_DSP_RAM_AW-1:0] host_addr_t;   // Bank on top
	typedef logic [`SCU_DSP_PROG_AW-1:0] prog_addr_t;
	typedef logic [`SCU_DSP_DATA_W-1:0] inst_word_t;
	typedef logic [`SCU_DSP_IMM_W-1:0] imm_t;

	// Encodings of instruction bits 29:26
	typedef enum logic [3:0] {
		ALU_NOP = 4'h0,
		ALU_AND = 4'h1,
		ALU_OR  = 4'h2,
		ALU_XOR = 4'h3,
		ALU_ADD = 4'h4,
		ALU_SUB = 4'h5,
		ALU_AD2 = 4'h6,
		ALU_SR  = 4'h8,
		ALU_RR  = 4'h9,
		ALU_SL  = 4'hA,
		ALU_RL  = 4'hB,
		ALU_RL8 = 4'hF
	} alu_op_e;

	typedef enum logic [1:0] {X_NONE, X_MEM_RX, X_MEM_PL, X_MUL_P} x_op_e;
	typedef enum logic [2:0] {Y_NONE, Y_MEM_RY, Y_CLR_A, Y_ALU_A, Y_MEM_ACL} y_op_e;
	typedef enum logic [2:0] {D1_NONE, D1_IMM, D1_MEM, D1_ACL, D1_ACH} d1_src_e;

	// All zero is a NOP
	typedef struct packed {
		x_op_e      x_op;
		bank_sel_t  x_bank;
		y_op_e      y_op;
		bank_sel_t  y_bank;
		d1_src_e    d1_src;
		bank_sel_t  d1_src_bank;
		imm_t       imm;
		bank_mask_t md_write;
		bank_mask_t ct_load;
		bank_mask_t ct_inc;
		logic       d1_to_rx;
		logic       d1_to_pl;
		alu_op_e    alu_op;
	} dsp_ctrl_t;

	typedef struct packed {
		logic       write;
		host_addr_t addr;
		data_word_t data;
	} host_port_t;

endpackage

// ==== rtl/dsp_fetch_decode.sv ====
module dsp_fetch_decode (
	input  logic                    clock,
	input  logic                    reset_n,
	input  logic                    exec,
	input  scu_dsp_pkg::inst_word_t inst_in,
	output scu_dsp_pkg::prog_addr_t inst_addr,
	output scu_dsp_pkg::dsp_ctrl_t  ctrl
);

	scu_dsp_pkg::inst_word_t fetch;
	logic                    exec_q;   // Fetch register holds a fresh instruction

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			fetch     <= '0;
			exec_q    <= 1'b0;
			inst_addr <= '0;
		end else begin
			exec_q <= exec;
			if (exec) begin
				fetch     <= inst_in;
				inst_addr <= inst_addr + 1'b1;
			end
		end
	end

	// Operation word: ALU 29:26, X bus 25:20, Y bus 19:14, D1 bus 13:0
	always_comb begin
		ctrl = '0;
		if (exec_q && fetch[31:30] == 2'b00) begin   // Other classes run as NOP
			ctrl.alu_op = scu_dsp_pkg::alu_op_e'(fetch[29:26]);

			case (fetch[25:23])
				3'b100: begin   // MOV [s],X
					ctrl.x_op   = scu_dsp_pkg::X_MEM_RX;
					ctrl.x_bank = fetch[21:20];
				end
				3'b011: begin   // MOV [s],P
					ctrl.x_op   = scu_dsp_pkg::X_MEM_PL;
					ctrl.x_bank = fetch[21:20];
				end
				3'b010: ctrl.x_op = scu_dsp_pkg::X_MUL_P;
				default: ;
			endcase
			if (fetch[22] && (fetch[25:23] == 3'b100 || fetch[25:23] == 3'b011)) begin
				ctrl.ct_inc[fetch[21:20]] = 1'b1;   // Step the bank actually read
			end

			case (fetch[19:17])
				3'b100: begin   // MOV [s],Y
					ctrl.y_op   = scu_dsp_pkg::Y_MEM_RY;
					ctrl.y_bank = fetch[15:14];
				end
				3'b011: begin   // MOV [s],A
					ctrl.y_op   = scu_dsp_pkg::Y_MEM_ACL;
					ctrl.y_bank = fetch[15:14];
				end
				3'b001: ctrl.y_op = scu_dsp_pkg::Y_CLR_A;
				3'b010: ctrl.y_op = scu_dsp_pkg::Y_ALU_A;
				default: ;
			endcase
			if (fetch[16] && (fetch[19:17] == 3'b100 || fetch[19:17] == 3'b011)) begin
				ctrl.ct_inc[fetch[15:14]] = 1'b1;
			end

			// Both MOV SImm,[d] and MOV [s],[d] share the destination field
			if (fetch[12]) begin
				case (fetch[11:8])
					4'h0, 4'h1, 4'h2, 4'h3: begin   // MDn, then CTn++
						ctrl.md_write[fetch[9:8]] = 1'b1;
						ctrl.ct_inc[fetch[9:8]]   = 1'b1;
					end
					4'h4: ctrl.d1_to_rx = 1'b1;
					4'h5: ctrl.d1_to_pl = 1'b1;
					4'hC, 4'hD, 4'hE, 4'hF: ctrl.ct_load[fetch[9:8]] = 1'b1;
					default: ;   // RA0, WA0, LOP, TOP not built
				endcase
			end

			if (fetch[13:12] == 2'b01) begin
				ctrl.d1_src = scu_dsp_pkg::D1_IMM;
				ctrl.imm    = fetch[7:0];
			end else if (fetch[13:12] == 2'b11) begin
				case (fetch[3:0])
					4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7: begin
						ctrl.d1_src      = scu_dsp_pkg::D1_MEM;
						ctrl.d1_src_bank = fetch[1:0];
						if (fetch[2]) begin
							ctrl.ct_inc[fetch[1:0]] = 1'b1;
						end
					end
					4'h9: ctrl.d1_src = scu_dsp_pkg::D1_ACL;
					4'hA: ctrl.d1_src = scu_dsp_pkg::D1_ACH;
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== rtl/data_ram_bank.sv ====
`include "scu_dsp_config.svh"

module data_ram_bank (
	input  logic                    clock,
	input  logic                    reset_n,
	input  scu_dsp_pkg::dsp_ctrl_t  ctrl,
	input  scu_dsp_pkg::host_port_t host,
	input  scu_dsp_pkg::acc_word_t  acc,
	output scu_dsp_pkg::data_word_t d0_bus_out,
	output scu_dsp_pkg::bank_mask_t md_wren,
	output scu_dsp_pkg::data_word_t x_bus,
	output scu_dsp_pkg::data_word_t y_bus,
	output scu_dsp_pkg::data_word_t d1_bus
);

	localparam int DEPTH = 1 << `SCU_DSP_RAM_AW;

	scu_dsp_pkg::data_word_t ct_rdata   [`SCU_DSP_NUM_BANKS];   // Read at CTn
	scu_dsp_pkg::data_word_t host_rdata [`SCU_DSP_NUM_BANKS];
	scu_dsp_pkg::bank_sel_t  host_bank;
	scu_dsp_pkg::ram_addr_t  host_word;
	scu_dsp_pkg::data_word_t ach_ext;

	assign {host_bank, host_word} = host.addr;

	for (genvar b = 0; b < `SCU_DSP_NUM_BANKS; b++) begin : g_bank
		scu_dsp_pkg::data_word_t mem [DEPTH];
		scu_dsp_pkg::ram_addr_t  ct;
		scu_dsp_pkg::ram_addr_t  wr_addr;
		scu_dsp_pkg::data_word_t wr_data;
		logic                    host_hit;

		// Host wins the port, DSP write is lost for this cycle
		assign host_hit   = host.write && host_bank == scu_dsp_pkg::bank_sel_t'(b);
		assign md_wren[b] = host_hit || ctrl.md_write[b];
		assign wr_addr    = host_hit ? host_word : ct;
		assign wr_data    = host_hit ? host.data : d1_bus;

		always_ff @(posedge clock) begin
			if (md_wren[b]) begin
				mem[wr_addr] <= wr_data;
			end
		end

		always_ff @(posedge clock) begin
			if (!reset_n) begin
				ct <= '0;
			end else if (ctrl.ct_load[b]) begin   // Load beats step
				ct <= d1_bus[`SCU_DSP_RAM_AW-1:0];
			end else if (ctrl.ct_inc[b]) begin
				ct <= ct + 1'b1;   // Still steps when host took the port
			end
		end

		assign ct_rdata[b]   = mem[ct];
		assign host_rdata[b] = mem[host_word];
	end

	assign d0_bus_out = host_rdata[host_bank];
	assign ach_ext    = scu_dsp_pkg::data_word_t'(acc[`SCU_DSP_ACC_W-1:`SCU_DSP_DATA_W]);

	always_comb begin
		x_bus = '0;
		y_bus = '0;
		if (ctrl.x_op == scu_dsp_pkg::X_MEM_RX || ctrl.x_op == scu_dsp_pkg::X_MEM_PL) begin
			x_bus = ct_rdata[ctrl.x_bank];
		end
		if (ctrl.y_op == scu_dsp_pkg::Y_MEM_RY || ctrl.y_op == scu_dsp_pkg::Y_MEM_ACL) begin
			y_bus = ct_rdata[ctrl.y_bank];
		end
		case (ctrl.d1_src)
			scu_dsp_pkg::D1_IMM: d1_bus = scu_dsp_pkg::data_word_t'(ctrl.imm);
			scu_dsp_pkg::D1_MEM: d1_bus = ct_rdata[ctrl.d1_src_bank];
			scu_dsp_pkg::D1_ACL: d1_bus = acc[`SCU_DSP_DATA_W-1:0];
			scu_dsp_pkg::D1_ACH: d1_bus = ach_ext;
			default:             d1_bus = '0;
		endcase
	end

endmodule

// ==== rtl/dsp_datapath.sv ====
`include "scu_dsp_config.svh"

module dsp_datapath (
	input  logic                    clock,
	input  logic                    reset_n,
	input  scu_dsp_pkg::dsp_ctrl_t  ctrl,
	input  scu_dsp_pkg::data_word_t x_bus,
	input  scu_dsp_pkg::data_word_t y_bus,
	input  scu_dsp_pkg::data_word_t d1_bus,
	output scu_dsp_pkg::acc_word_t  acc
);

	localparam int DW = `SCU_DSP_DATA_W;

	scu_dsp_pkg::data_word_t rx;
	scu_dsp_pkg::data_word_t ry;
	scu_dsp_pkg::acc_word_t  p;        // PH:PL
	scu_dsp_pkg::acc_word_t  a;        // ACH:ACL
	scu_dsp_pkg::acc_word_t  mul_lo;
	scu_dsp_pkg::acc_word_t  alu_res;
	scu_dsp_pkg::data_word_t acl;
	scu_dsp_pkg::data_word_t pl;
	scu_dsp_pkg::data_word_t alu_sum;
	scu_dsp_pkg::data_word_t alu_diff;

	assign acc      = a;
	assign acl      = a[DW-1:0];
	assign pl       = p[DW-1:0];
	assign mul_lo   = rx * ry;   // Evaluated at 48 bits, upper product bits dropped
	assign alu_sum  = acl + pl;
	assign alu_diff = acl - pl;

	// Single-word ops and shifts land zero-extended in A
	always_comb begin
		alu_res = a;
		case (ctrl.alu_op)
			scu_dsp_pkg::ALU_AND: alu_res = scu_dsp_pkg::acc_word_t'(acl & pl);
			scu_dsp_pkg::ALU_OR:  alu_res = scu_dsp_pkg::acc_word_t'(acl | pl);
			scu_dsp_pkg::ALU_XOR: alu_res = scu_dsp_pkg::acc_word_t'(acl ^ pl);
			scu_dsp_pkg::ALU_ADD: alu_res = scu_dsp_pkg::acc_word_t'(alu_sum);
			scu_dsp_pkg::ALU_SUB: alu_res = scu_dsp_pkg::acc_word_t'(alu_diff);
			scu_dsp_pkg::ALU_AD2: alu_res = a + p;   // Full width, wraps
			scu_dsp_pkg::ALU_SR:  alu_res = scu_dsp_pkg::acc_word_t'({acl[DW-1], acl[DW-1:1]});
			scu_dsp_pkg::ALU_RR:  alu_res = scu_dsp_pkg::acc_word_t'({acl[0], acl[DW-1:1]});
			scu_dsp_pkg::ALU_SL:  alu_res = scu_dsp_pkg::acc_word_t'({acl[DW-2:0], 1'b0});
			scu_dsp_pkg::ALU_RL:  alu_res = scu_dsp_pkg::acc_word_t'({acl[DW-2:0], acl[DW-1]});
			scu_dsp_pkg::ALU_RL8: alu_res = scu_dsp_pkg::acc_word_t'({acl[DW-9:0], acl[DW-1:DW-8]});
			default: ;   // NOP and unused codes
		endcase
	end

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			rx <= '0;
			ry <= '0;
			p  <= '0;
			a  <= '0;
		end else begin
			if (ctrl.d1_to_rx) begin
				rx <= d1_bus;
			end else if (ctrl.x_op == scu_dsp_pkg::X_MEM_RX) begin
				rx <= x_bus;
			end

			if (ctrl.y_op == scu_dsp_pkg::Y_MEM_RY) begin
				ry <= y_bus;
			end

			// PL loads leave PH alone
			if (ctrl.d1_to_pl) begin
				p[DW-1:0] <= d1_bus;
			end else if (ctrl.x_op == scu_dsp_pkg::X_MEM_PL) begin
				p[DW-1:0] <= x_bus;
			end else if (ctrl.x_op == scu_dsp_pkg::X_MUL_P) begin
				p <= mul_lo;
			end

			case (ctrl.y_op)
				scu_dsp_pkg::Y_CLR_A:   a <= '0;
				scu_dsp_pkg::Y_ALU_A:   a <= alu_res;
				scu_dsp_pkg::Y_MEM_ACL: a[DW-1:0] <= y_bus;   // ACH kept
				default: ;
			endcase
		end
	end

endmodule

// ==== rtl/scu_dsp_top.sv ====
module scu_dsp_top (
	input  logic                    clock,
	input  logic                    reset_n,

	// D0 host port
	input  scu_dsp_pkg::data_word_t d0_bus_in,
	input  scu_dsp_pkg::host_addr_t d0_addr,
	input  logic                    d0_write,
	output scu_dsp_pkg::data_word_t d0_bus_out,

	// Program side
	input  logic                    exec,
	input  scu_dsp_pkg::inst_word_t inst_in,
	output scu_dsp_pkg::prog_addr_t inst_addr,

	output scu_dsp_pkg::bank_mask_t md_wren
);

	scu_dsp_pkg::dsp_ctrl_t  ctrl;
	scu_dsp_pkg::host_port_t host;
	scu_dsp_pkg::data_word_t x_bus;
	scu_dsp_pkg::data_word_t y_bus;
	scu_dsp_pkg::data_word_t d1_bus;
	scu_dsp_pkg::acc_word_t  acc;

	assign host.write = d0_write;
	assign host.addr  = d0_addr;
	assign host.data  = d0_bus_in;

	dsp_fetch_decode u_fetch_decode (
		.clock     (clock),
		.reset_n   (reset_n),
		.exec      (exec),
		.inst_in   (inst_in),
		.inst_addr (inst_addr),
		.ctrl      (ctrl)
	);

	data_ram_bank u_ram_bank (
		.clock      (clock),
		.reset_n    (reset_n),
		.ctrl       (ctrl),
		.host       (host),
		.acc        (acc),
		.d0_bus_out (d0_bus_out),
		.md_wren    (md_wren),
		.x_bus      (x_bus),
		.y_bus      (y_bus),
		.d1_bus     (d1_bus)
	);

	dsp_datapath u_datapath (
		.clock   (clock),
		.reset_n (reset_n),
		.ctrl    (ctrl),
		.x_bus   (x_bus),
		.y_bus   (y_bus),
		.d1_bus  (d1_bus),
		.acc     (acc)
	);

endmodule

// ==== dv/scu_dsp_sva.sv ====
module scu_dsp_sva (
	input logic                    clock,
	input logic                    reset_n,
	input logic                    exec,
	input logic                    d0_write,
	input scu_dsp_pkg::prog_addr_t inst_addr,
	input scu_dsp_pkg::bank_mask_t md_wren
);
	timeunit 1ns;
	timeprecision 100ps;

	int error_count = 0;   // Failed assertions so far

	fetch_step: assert property (@(posedge clock) disable iff (!reset_n)
		exec |=> inst_addr == scu_dsp_pkg::prog_addr_t'($past(inst_addr) + 1'b1))
	else begin
		$error("inst_addr did not advance by one after exec");
		error_count++;
	end

	fetch_hold: assert property (@(posedge clock) disable iff (!reset_n)
		!exec |=> $stable(inst_addr))
	else begin
		$error("inst_addr changed without exec");
		error_count++;
	end

	wren_after_reset: assert property (@(posedge clock) !reset_n |=> md_wren == '0)
	else begin
		$error("md_wren active right after reset");
		error_count++;
	end

	// Only an executing instruction or the host may write
	wren_source: assert property (@(posedge clock) disable iff (!reset_n)
		(|md_wren) |-> ($past(exec) || d0_write))
	else begin
		$error("md_wren active with no instruction and no host write");
		error_count++;
	end

endmodule

bind scu_dsp_top scu_dsp_sva u_sva (
	.clock     (clock),
	.reset_n   (reset_n),
	.exec      (exec),
	.d0_write  (d0_write),
	.inst_addr (inst_addr),
	.md_wren   (md_wren)
);

// ==== dv/tb_scu_dsp.sv ====
module tb_scu_dsp;
	timeunit 1ns;
	timeprecision 100ps;

	// Instruction and host access counts of the test groups in run order
	localparam int NUM_INSTS   = 4 * 5 + 9 + 3 + 10 * 3 + 3;
	localparam int NUM_HOST    = 4 * 4 * 2 + 4 * 4 + 4 + 10 * 3 + 3;
	localparam int WATCHDOG_NS = (NUM_INSTS + NUM_HOST) * 4 * 4 * 2;

	logic                    clock;
	logic                    reset_n;
	logic                    exec;
	logic                    d0_write;
	scu_dsp_pkg::inst_word_t inst_in;
	scu_dsp_pkg::host_addr_t d0_addr;
	scu_dsp_pkg::data_word_t d0_bus_in;
	scu_dsp_pkg::data_word_t d0_bus_out;
	scu_dsp_pkg::prog_addr_t inst_addr;
	scu_dsp_pkg::bank_mask_t md_wren;
	logic [15:0]             lfsr_state;
	int                      exec_count;

	scu_dsp_top dut (
		.clock      (clock),
		.reset_n    (reset_n),
		.d0_bus_in  (d0_bus_in),
		.d0_addr    (d0_addr),
		.d0_write   (d0_write),
		.d0_bus_out (d0_bus_out),
		.exec       (exec),
		.inst_in    (inst_in),
		.inst_addr  (inst_addr),
		.md_wren    (md_wren)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the DSP tests did not finish in the expected time");
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

	// Bound assertion failures end the run at once
	initial begin
		wait (dut.u_sva.error_count != 0);
		$display("A bound assertion on fetch timing or write enables failed");
		$display("Simulation failed");
		$fatal(1, "bound assertion failed");
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	// Operation word has ALU in 29:26, X in 25:20, Y in 19:14 and D1 in 13:0
	function automatic scu_dsp_pkg::inst_word_t imm_to(input logic [3:0] dest,
			input logic [7:0] imm);
		return {18'h0, 2'b01, dest, imm};
	endfunction

	function automatic scu_dsp_pkg::inst_word_t mov_d1(input logic [3:0] dest,
			input logic [3:0] src);
		return {18'h0, 2'b11, dest, 4'h0, src};
	endfunction

	function automatic scu_dsp_pkg::inst_word_t op_word(input logic [3:0] alu,
			input logic [5:0] x, input logic [5:0] y);
		return {2'b00, alu, x, y, 14'h0};
	endfunction

	function automatic scu_dsp_pkg::host_addr_t bank_word_addr(input int bank,
			input logic [31:0] word);
		return {scu_dsp_pkg::bank_sel_t'(bank), scu_dsp_pkg::ram_addr_t'(word)};
	endfunction

	function automatic logic [31:0] alu_expect(input logic [3:0] op, input logic [31:0] a,
			input logic [31:0] p);
		case (op)
			4'h1: return a & p;
			4'h2: return a | p;
			4'h3: return a ^ p;
			4'h4: return a + p;
			4'h5: return a - p;
			4'h8: return $signed(a) >>> 1;
			4'h9: return (a >> 1) | (a << 31);
			4'hA: return a << 1;
			4'hB: return (a << 1) | (a >> 31);
			4'hF: return (a << 8) | (a >> 24);
			default: return a;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected)
		else begin
			$display("error %s: expected %h, actual %h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic issue(input scu_dsp_pkg::inst_word_t inst);
		exec    = 1'b1;
		inst_in = inst;
		@(posedge clock);   // Fetch
		#1;
		exec = 1'b0;
		exec_count++;
		@(posedge clock);   // Execute
		#1;
		check_value("fetch address", 32'(scu_dsp_pkg::prog_addr_t'(exec_count)), 32'(inst_addr));
	endtask

	// Host write lands in the same cycle the instruction executes
	task automatic issue_with_host_write(input scu_dsp_pkg::inst_word_t inst,
			input scu_dsp_pkg::host_addr_t addr, input logic [31:0] data);
		exec    = 1'b1;
		inst_in = inst;
		@(posedge clock);
		#1;
		exec      = 1'b0;
		exec_count++;
		d0_write  = 1'b1;
		d0_addr   = addr;
		d0_bus_in = data;
		@(posedge clock);
		#1;
		d0_write = 1'b0;
		check_value("fetch address", 32'(scu_dsp_pkg::prog_addr_t'(exec_count)), 32'(inst_addr));
	endtask

	task automatic host_write(input scu_dsp_pkg::host_addr_t addr, input logic [31:0] data);
		d0_write  = 1'b1;
		d0_addr   = addr;
		d0_bus_in = data;
		@(posedge clock);
		#1;
		d0_write = 1'b0;
	endtask

	task automatic check_read(input string name, input scu_dsp_pkg::host_addr_t addr,
			input logic [31:0] expected);
		d0_addr = addr;
		@(posedge clock);
		#1;
		check_value(name, expected, d0_bus_out);
	endtask

	task automatic host_port_roundtrip();
		logic [31:0] word;
		logic [31:0] value;
		for (int b = 0; b < 4; b++) begin
			for (int i = 0; i < 4; i++) begin
				take_bits(6, word);
				take_bits(32, value);
				host_write(bank_word_addr(b, word), value);
				check_read("host port", bank_word_addr(b, word), value);
			end
		end
	endtask

	task automatic immediate_stores();
		logic [31:0] base;
		logic [31:0] vals [4];
		for (int b = 0; b < 4; b++) begin
			take_bits(6, base);
			issue(imm_to({2'b11, 2'(b)}, base[7:0]));   // CTn
			for (int i = 0; i < 4; i++) begin
				take_bits(8, vals[i]);
				issue(imm_to({2'b00, 2'(b)}, vals[i][7:0]));   // MDn
			end
			for (int i = 0; i < 4; i++) begin
				check_read("immediate store", bank_word_addr(b, base + i), vals[i]);
			end
		end
	endtask

	task automatic multiply_path();
		logic [31:0] op1;
		logic [31:0] op2;
		logic [31:0] ca;
		logic [31:0] cb;
		logic [31:0] cc;
		logic [63:0] prod;
		take_bits(32, op1);
		take_bits(32, op2);
		take_bits(6, ca);
		take_bits(6, cb);
		take_bits(6, cc);
		issue(imm_to(4'hC, ca[7:0]));
		issue(imm_to(4'hD, cb[7:0]));
		host_write(bank_word_addr(0, ca), op1);
		host_write(bank_word_addr(1, cb), op2);
		issue(op_word(4'h0, {3'b100, 1'b0, 2'd0}, {3'b100, 1'b0, 2'd1}));   // MD0 to RX, MD1 to RY
		issue(op_word(4'h0, {3'b010, 3'b000}, 6'h0));   // MOV MUL,P
		issue(op_word(4'h0, 6'h0, {3'b001, 3'b000}));   // CLR A
		issue(op_word(4'h6, 6'h0, {3'b010, 3'b000}));   // AD2 adds P to the cleared A
		issue(imm_to(4'hE, cc[7:0]));
		issue(mov_d1(4'h2, 4'h9));   // ACL
		issue(mov_d1(4'h2, 4'hA));   // ACH
		prod = 64'(op1) * 64'(op2);
		check_read("multiply low", bank_word_addr(2, cc), prod[31:0]);
		check_read("multiply high", bank_word_addr(2, cc + 1), {16'h0, prod[47:32]});
	endtask

	task automatic alu_operations();
		logic [3:0]  ops [10];
		logic [31:0] ca;
		logic [31:0] cb;
		logic [31:0] cd;
		logic [31:0] op_a;
		logic [31:0] op_p;
		ops = '{4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h8, 4'h9, 4'hA, 4'hB, 4'hF};
		take_bits(6, ca);
		take_bits(6, cb);
		take_bits(6, cd);
		issue(imm_to(4'hC, ca[7:0]));
		issue(imm_to(4'hD, cb[7:0]));
		issue(imm_to(4'hF, cd[7:0]));
		foreach (ops[k]) begin
			take_bits(32, op_a);
			take_bits(32, op_p);
			host_write(bank_word_addr(0, ca), op_a);
			host_write(bank_word_addr(1, cb), op_p);
			issue(op_word(4'h0, {3'b011, 1'b0, 2'd1}, {3'b011, 1'b0, 2'd0}));   // PL and ACL
			issue(op_word(ops[k], 6'h0, {3'b010, 3'b000}));
			issue(mov_d1(4'h3, 4'h9));   // CT3 steps each store
			check_read($sformatf("alu op %h", ops[k]), bank_word_addr(3, cd + k),
				alu_expect(ops[k], op_a, op_p));
		end
	endtask

	task automatic host_priority();
		logic [31:0] base;
		logic [31:0] imm1;
		logic [31:0] imm2;
		logic [31:0] host_val;
		take_bits(6, base);
		take_bits(8, imm1);
		take_bits(8, imm2);
		take_bits(32, host_val);
		issue(imm_to(4'hE, base[7:0]));
		issue_with_host_write(imm_to(4'h2, imm1[7:0]), bank_word_addr(2, base), host_val);
		issue(imm_to(4'h2, imm2[7:0]));
		check_read("host priority", bank_word_addr(2, base), host_val);
		check_read("counter step", bank_word_addr(2, base + 1), imm2);
	endtask

	initial begin
		reset_n    = 1'b0;
		exec       = 1'b0;
		inst_in    = '0;
		d0_write   = 1'b0;
		d0_addr    = '0;
		d0_bus_in  = '0;
		lfsr_state = 16'd73;
		exec_count = 0;
		repeat (2) @(posedge clock);
		#1;
		reset_n = 1'b1;
		@(posedge clock);   // Idle cycle after reset
		#1;
		check_value("reset address", 32'h0, 32'(inst_addr));

		host_port_roundtrip();
		immediate_stores();
		multiply_path();
		alu_operations();
		host_priority();

		if (dut.u_sva.error_count == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			$display("Simulation failed");
			$fatal(1, "bound assertions reported errors");
		end
	end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/scu_dsp_pkg.sv
rtl/dsp_fetch_decode.sv
rtl/data_ram_bank.sv
rtl/dsp_datapath.sv
rtl/scu_dsp_top.sv
dv/scu_dsp_sva.sv
dv/tb_scu_dsp.sv

// ==== Bender.yml ====
package:
  name: scu_dsp

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/scu_dsp_pkg.sv
      - rtl/dsp_fetch_decode.sv
      - rtl/data_ram_bank.sv
      - rtl/dsp_datapath.sv
      - rtl/scu_dsp_top.sv
  - target: test
    files:
      - dv/scu_dsp_sva.sv
      - dv/tb_scu_dsp.sv
